//--- bench/tiny_core_props.sv
//--------------------------------------------------------------------------
// concurrent checks on the core's external channels, bound to tiny_core
//--------------------------------------------------------------------------

`timescale 1ns/100ps

module tiny_core_props (
  input logic                      clk,
  input logic                      reset,
  input core_pipe_pkg::word_chan_t mngr_out,
  input logic                      commit,
  input logic                      inst_credit,
  input logic                      mngr_credit
);

  // number of assertion failures seen so far
  int fail_count = 0;

  // quiet through reset and the first cycle after it
  a_quiet_after_reset: assert property (@(posedge clk)
    reset |=> !mngr_out.valid && !commit)
    else begin
      $error("output or commit active during reset");
      fail_count++;
    end

  // an output beat is always a retiring csrw
  a_out_with_commit: assert property (@(posedge clk) disable iff (reset)
    mngr_out.valid |-> commit)
    else begin
      $error("manager output without commit");
      fail_count++;
    end

  // credit lines driven to known levels
  a_credits_known: assert property (@(posedge clk) disable iff (reset)
    !$isunknown({inst_credit, mngr_credit}))
    else begin
      $error("credit line unknown");
      fail_count++;
    end

endmodule

bind tiny_core tiny_core_props i_props (
  .clk         (clk),
  .reset       (reset),
  .mngr_out    (mngr_out),
  .commit      (commit),
  .inst_credit (inst_credit),
  .mngr_credit (mngr_credit)
);

//--- bench/tiny_core_tb.sv
//--------------------------------------------------------------------------
// directed testbench for the three-stage core; drives all credit channels,
// predicts manager outputs from its own ALU model and counts commits
//--------------------------------------------------------------------------

`timescale 1ns/100ps

module tiny_core_tb;

  import core_isa_pkg::*;
  import core_pipe_pkg::*;

  localparam int CLK_PERIOD = 4;
  // echo 16, alu 22, hazard 7, back-pressure 12, x0 and unknown 6
  localparam int TOTAL_INSTS     = 63;
  localparam int WATCHDOG_CYCLES = TOTAL_INSTS * 200 + 100;
  localparam int HOLD_CYCLES     = 60;

  logic       clk;
  logic       reset;
  inst_chan_t inst_in;
  logic       inst_credit;
  word_chan_t mngr_in;
  logic       mngr_credit;
  word_chan_t mngr_out;
  logic       mngr_out_credit;
  logic       commit;

  // sender credits, result counters and credits owed back to the core
  int    inst_cr;
  int    mngr_cr;
  int    commit_cnt;
  int    out_cnt;
  int    owed;
  logic  withhold;
  inst_t prog_q[$];
  word_t word_q[$];
  word_t expect_q[$];

  tiny_core i_tiny_core (
    .clk             (clk),
    .reset           (reset),
    .inst_in         (inst_in),
    .inst_credit     (inst_credit),
    .mngr_in         (mngr_in),
    .mngr_credit     (mngr_credit),
    .mngr_out        (mngr_out),
    .mngr_out_credit (mngr_out_credit),
    .commit          (commit)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //------------------------------------------------------------------------
  // error reporting and compares
  //------------------------------------------------------------------------

  task automatic abort_run();
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic compare_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic compare_count(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  //------------------------------------------------------------------------
  // instruction encoding and reference ALU
  //------------------------------------------------------------------------

  function automatic inst_t encode_rtype(input logic [6:0] f7, input logic [2:0] f3,
                                         input reg_addr_t rd, input reg_addr_t rs1,
                                         input reg_addr_t rs2);
    inst_t i;
    i.r.funct7 = f7;
    i.r.rs2    = rs2;
    i.r.rs1    = rs1;
    i.r.funct3 = f3;
    i.r.rd     = rd;
    i.r.opcode = OPC_OP;
    return i;
  endfunction

  function automatic inst_t encode_csr(input logic [2:0] f3, input csr_addr_t csr,
                                       input reg_addr_t rd, input reg_addr_t rs1);
    inst_t i;
    i.c.csr    = csr;
    i.c.rs1    = rs1;
    i.c.funct3 = f3;
    i.c.rd     = rd;
    i.c.opcode = OPC_SYSTEM;
    return i;
  endfunction

  // sel order: add sub sll slt sltu xor srl sra or and, sources x1 and x2
  function automatic inst_t alu_inst(input int sel, input reg_addr_t rd);
    case (sel)
      0:       return encode_rtype(F7_BASE, 3'b000, rd, 5'd1, 5'd2);
      1:       return encode_rtype(F7_ALT,  3'b000, rd, 5'd1, 5'd2);
      2:       return encode_rtype(F7_BASE, 3'b001, rd, 5'd1, 5'd2);
      3:       return encode_rtype(F7_BASE, 3'b010, rd, 5'd1, 5'd2);
      4:       return encode_rtype(F7_BASE, 3'b011, rd, 5'd1, 5'd2);
      5:       return encode_rtype(F7_BASE, 3'b100, rd, 5'd1, 5'd2);
      6:       return encode_rtype(F7_BASE, 3'b101, rd, 5'd1, 5'd2);
      7:       return encode_rtype(F7_ALT,  3'b101, rd, 5'd1, 5'd2);
      8:       return encode_rtype(F7_BASE, 3'b110, rd, 5'd1, 5'd2);
      default: return encode_rtype(F7_BASE, 3'b111, rd, 5'd1, 5'd2);
    endcase
  endfunction

  function automatic word_t model_alu(input int sel, input word_t a, input word_t b);
    case (sel)
      0:       return a + b;
      1:       return a - b;
      2:       return a << b[4:0];
      3:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      4:       return (a < b) ? 32'd1 : 32'd0;
      5:       return a ^ b;
      6:       return a >> b[4:0];
      7:       return word_t'($signed(a) >>> b[4:0]);
      8:       return a | b;
      default: return a & b;
    endcase
  endfunction

  //------------------------------------------------------------------------
  // channel drivers and monitors
  //------------------------------------------------------------------------

  // one beat per credit, valid dropped while no credit is left
  task automatic send_program();
    while (prog_q.size() > 0) begin
      @(posedge clk);
      while (inst_cr == 0) begin
        inst_in.valid <= 1'b0;
        @(posedge clk);
      end
      inst_in.valid <= 1'b1;
      inst_in.inst  <= prog_q.pop_front();
      inst_cr = inst_cr - 1;
    end
    @(posedge clk);
    inst_in.valid <= 1'b0;
  endtask

  task automatic send_words();
    while (word_q.size() > 0) begin
      @(posedge clk);
      while (mngr_cr == 0) begin
        mngr_in.valid <= 1'b0;
        @(posedge clk);
      end
      mngr_in.valid <= 1'b1;
      mngr_in.data  <= word_q.pop_front();
      mngr_cr = mngr_cr - 1;
    end
    @(posedge clk);
    mngr_in.valid <= 1'b0;
  endtask

  // credits, commits and outputs sampled mid-cycle
  always @(negedge clk) begin
    if (!reset) begin
      if (inst_credit)
        inst_cr = inst_cr + 1;
      if (mngr_credit)
        mngr_cr = mngr_cr + 1;
      if (commit)
        commit_cnt = commit_cnt + 1;
      if (mngr_out.valid) begin
        out_cnt = out_cnt + 1;
        owed    = owed + 1;
        if (expect_q.size() == 0) begin
          $display("manager output word arrived when none was expected");
          abort_run();
        end else begin
          compare_word(mngr_out.data, expect_q.pop_front(), "manager output");
        end
      end
    end
  end

  // output credit sink, one credit back per cycle unless held off
  always @(posedge clk) begin
    if (!withhold && owed > 0) begin
      mngr_out_credit <= 1'b1;
      owed = owed - 1;
    end else begin
      mngr_out_credit <= 1'b0;
    end
  end

  // feed both queues, wait for every commit, then check credits are home
  task automatic run_program(input int n_commits);
    commit_cnt = 0;
    fork
      send_program();
      send_words();
    join
    while (commit_cnt < n_commits)
      @(posedge clk);
    repeat (4) @(posedge clk);
    compare_count(commit_cnt, n_commits, "commit count");
    compare_count(expect_q.size(), 0, "outputs still missing");
    compare_count(inst_cr, INST_CREDITS, "instruction credits");
    compare_count(mngr_cr, MNGR_CREDITS, "manager credits");
  endtask

  //------------------------------------------------------------------------
  // directed tests
  //------------------------------------------------------------------------

  task automatic test_idle();
    repeat (20) begin
      @(negedge clk);
      compare_word(word_t'({mngr_out.valid, commit, inst_credit, mngr_credit}), '0,
                   "idle outputs");
    end
  endtask

  task automatic test_echo();
    word_t w;
    for (int i = 0; i < 8; i++) begin
      w = $urandom;
      word_q.push_back(w);
      expect_q.push_back(w);
      prog_q.push_back(encode_csr(F3_CSRR, CSR_MNGR2PROC, 5'd1, 5'd0));
      prog_q.push_back(encode_csr(F3_CSRW, CSR_PROC2MNGR, 5'd0, 5'd1));
    end
    run_program(16);
  endtask

  task automatic test_alu();
    word_t a;
    word_t b;
    a = $urandom;
    b = $urandom;
    word_q.push_back(a);
    word_q.push_back(b);
    prog_q.push_back(encode_csr(F3_CSRR, CSR_MNGR2PROC, 5'd1, 5'd0));
    prog_q.push_back(encode_csr(F3_CSRR, CSR_MNGR2PROC, 5'd2, 5'd0));
    for (int sel = 0; sel < 10; sel++) begin
      prog_q.push_back(alu_inst(sel, reg_addr_t'(sel + 3)));
      prog_q.push_back(encode_csr(F3_CSRW, CSR_PROC2MNGR, 5'd0, reg_addr_t'(sel + 3)));
      expect_q.push_back(model_alu(sel, a, b));
    end
    run_program(22);
  endtask

  // each add reads the result of the one right before it
  task automatic test_hazard();
    word_t r [1:6];
    int    src2;
    r[1] = $urandom;
    word_q.push_back(r[1]);
    prog_q.push_back(encode_csr(F3_CSRR, CSR_MNGR2PROC, 5'd1, 5'd0));
    for (int k = 2; k <= 6; k++) begin
      src2 = (k == 2) ? 1 : k - 2;
      r[k] = r[k-1] + r[src2];
      prog_q.push_back(encode_rtype(F7_BASE, 3'b000, reg_addr_t'(k), reg_addr_t'(k - 1),
                                    reg_addr_t'(src2)));
    end
    prog_q.push_back(encode_csr(F3_CSRW, CSR_PROC2MNGR, 5'd0, 5'd6));
    expect_q.push_back(r[6]);
    run_program(7);
  endtask

  task automatic test_backpressure();
    word_t w;
    withhold = 1'b1;
    out_cnt  = 0;
    for (int k = 1; k <= 6; k++) begin
      w = $urandom;
      word_q.push_back(w);
      expect_q.push_back(w);
      prog_q.push_back(encode_csr(F3_CSRR, CSR_MNGR2PROC, reg_addr_t'(k), 5'd0));
    end
    for (int k = 1; k <= 6; k++)
      prog_q.push_back(encode_csr(F3_CSRW, CSR_PROC2MNGR, 5'd0, reg_addr_t'(k)));
    fork
      run_program(12);
      begin
        repeat (HOLD_CYCLES) @(posedge clk);
        compare_count(out_cnt, OUT_CREDITS, "outputs while credits withheld");
        @(negedge clk);
        withhold = 1'b0;
      end
    join
    compare_count(out_cnt, 6, "outputs after credits returned");
  endtask

  task automatic test_zero_and_unknown();
    word_t w0;
    word_t w7;
    inst_t unk;
    w7 = $urandom;
    w0 = $urandom;
    word_q.push_back(w7);
    word_q.push_back(w0);
    // custom opcode aimed at x7 with x0 sources, any write would clear x7
    unk          = encode_rtype(F7_BASE, 3'b000, 5'd7, 5'd0, 5'd0);
    unk.r.opcode = 7'b0001011;
    prog_q.push_back(encode_csr(F3_CSRR, CSR_MNGR2PROC, 5'd7, 5'd0));
    prog_q.push_back(encode_rtype(F7_BASE, 3'b000, 5'd0, 5'd7, 5'd7));
    prog_q.push_back(encode_csr(F3_CSRR, CSR_MNGR2PROC, 5'd0, 5'd0));
    prog_q.push_back(encode_csr(F3_CSRW, CSR_PROC2MNGR, 5'd0, 5'd0));
    prog_q.push_back(unk);
    prog_q.push_back(encode_csr(F3_CSRW, CSR_PROC2MNGR, 5'd0, 5'd7));
    expect_q.push_back('0);
    expect_q.push_back(w7);
    run_program(6);
  endtask

  //------------------------------------------------------------------------
  // run control
  //------------------------------------------------------------------------

  initial begin
    #(CLK_PERIOD * WATCHDOG_CYCLES);
    $display("watchdog expired, the core stopped making progress");
    abort_run();
  end

  initial begin
    void'($urandom(25));
    clk             = 1'b0;
    reset           = 1'b1;
    inst_in         = '0;
    mngr_in         = '0;
    mngr_out_credit = 1'b0;
    withhold        = 1'b0;
    inst_cr         = INST_CREDITS;
    mngr_cr         = MNGR_CREDITS;
    commit_cnt      = 0;
    out_cnt         = 0;
    owed            = 0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    test_idle();
    test_echo();
    test_alu();
    test_hazard();
    test_backpressure();
    test_zero_and_unknown();
    if (i_tiny_core.i_props.fail_count != 0) begin
      $display("a concurrent assertion on the core failed during the run");
      abort_run();
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# builds the tiny_core testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tiny_core_tb \
  -f tiny_core.f -o sim_tiny_core \
  && ./obj_dir/sim_tiny_core > sim.log 2>&1 \
  || echo "STATUS: FAIL" >> sim.log

cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0

//--- source/alu_execute.sv
//--------------------------------------------------------------------------
// X stage; one pipeline register and the ALU, holds while W holds
//--------------------------------------------------------------------------

`timescale 1ns/100ps

module alu_execute (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    issue,
  input  core_pipe_pkg::exec_op_t op,
  input  logic                    w_hold,
  output logic                    x_hold,
  output core_pipe_pkg::dest_t    x_dest,
  output logic                    res_valid,
  output core_pipe_pkg::result_t  res
);

  import core_isa_pkg::*;
  import core_pipe_pkg::*;

  logic     full;
  exec_op_t op_x;
  word_t    alu_out;
  logic [4:0] shamt;

  // full entry cannot move while W is stuck
  assign x_hold = full && w_hold;

  always_ff @(posedge clk) begin
    if (reset)
      full <= 1'b0;
    else if (!x_hold)
      full <= issue;
  end

  // payload
  always_ff @(posedge clk) begin
    if (!x_hold && issue)
      op_x <= op;
  end

  // pending write for the hazard check in D
  assign x_dest.wen = full && op_x.wen;
  assign x_dest.rd  = op_x.rd;

  //------------------------------------------------------------------------
  // ALU
  //------------------------------------------------------------------------

  assign shamt = op_x.op_b[4:0];

  always_comb begin
    case (op_x.alu_fn)
      ALU_ADD:    alu_out = op_x.op_a + op_x.op_b;
      ALU_SUB:    alu_out = op_x.op_a - op_x.op_b;
      ALU_AND:    alu_out = op_x.op_a & op_x.op_b;
      ALU_OR:     alu_out = op_x.op_a | op_x.op_b;
      ALU_XOR:    alu_out = op_x.op_a ^ op_x.op_b;
      ALU_SLT:    alu_out = word_t'($signed(op_x.op_a) < $signed(op_x.op_b));
      ALU_SLTU:   alu_out = word_t'(op_x.op_a < op_x.op_b);
      ALU_SLL:    alu_out = op_x.op_a << shamt;
      ALU_SRL:    alu_out = op_x.op_a >> shamt;
      ALU_SRA:    alu_out = word_t'($signed(op_x.op_a) >>> shamt);
      ALU_PASS_A: alu_out = op_x.op_a;
      default:    alu_out = '0;
    endcase
  end

  // W takes this whenever it is not holding
  assign res_valid   = full;
  assign res.value   = alu_out;
  assign res.rd      = op_x.rd;
  assign res.wen     = op_x.wen;
  assign res.to_mngr = op_x.to_mngr;

endmodule

//--- source/core_isa_pkg.sv
//--------------------------------------------------------------------------
// instruction set view of the core: field widths, opcodes, CSR numbers
// and the instruction word decoded as either R-type or CSR format
//--------------------------------------------------------------------------

package core_isa_pkg;

  // data path and register specifier widths
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [11:0]           csr_addr_t;

  // major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // csrr is csrrs with rs1 = x0, csrw is csrrw with rd = x0
  localparam logic [2:0] F3_CSRR = 3'b010;
  localparam logic [2:0] F3_CSRW = 3'b001;

  // funct7 selects add/sub and srl/sra
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // manager queue CSRs
  localparam csr_addr_t CSR_MNGR2PROC = 12'hFC0;
  localparam csr_addr_t CSR_PROC2MNGR = 12'h7C0;

  // register-register format
  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } inst_r_t;

  // CSR format, csr sits where funct7 and rs2 are in R-type
  typedef struct packed {
    csr_addr_t  csr;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } inst_csr_t;

  // one 32-bit word, two readings
  typedef union packed {
    inst_r_t   r;
    inst_csr_t c;
  } inst_t;

endpackage

//--- source/core_pipe_pkg.sv
//--------------------------------------------------------------------------
// pipeline view of the core: ALU functions, stage-to-stage records,
// credit channel records and the credit count of each channel
//--------------------------------------------------------------------------

package core_pipe_pkg;

  import core_isa_pkg::*;

  // ALU function codes
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SLT    = 4'd5,
    ALU_SLTU   = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_SRL    = 4'd8,
    ALU_SLL    = 4'd9,
    ALU_PASS_A = 4'd11
  } alu_fn_t;

  // decode to execute
  typedef struct packed {
    alu_fn_t   alu_fn;
    word_t     op_a;
    word_t     op_b;
    reg_addr_t rd;
    logic      wen;
    logic      to_mngr;
  } exec_op_t;

  // execute to result
  typedef struct packed {
    word_t     value;
    reg_addr_t rd;
    logic      wen;
    logic      to_mngr;
  } result_t;

  // pending register write, seen by the hazard check in decode
  typedef struct packed {
    logic      wen;
    reg_addr_t rd;
  } dest_t;

  // credit channels, valid is one beat and spends one credit
  typedef struct packed {
    logic  valid;
    inst_t inst;
  } inst_chan_t;

  typedef struct packed {
    logic  valid;
    word_t data;
  } word_chan_t;

  localparam int INST_CREDITS = 4;
  localparam int MNGR_CREDITS = 2;
  localparam int OUT_CREDITS  = 2;

endpackage

//--- source/credit_queue.sv
//--------------------------------------------------------------------------
// receive FIFO for a credit channel; one credit goes back per dequeue,
// DEPTH must match the credits the sender starts with
//--------------------------------------------------------------------------

`timescale 1ns/100ps

module credit_queue #(
  parameter int DEPTH = 2
) (
  input  logic                      clk,
  input  logic                      reset,
  input  core_pipe_pkg::word_chan_t in,
  output logic                      credit,
  input  logic                      deq,
  output core_isa_pkg::word_t       head,
  output logic                      head_valid
);

  import core_isa_pkg::*;

  word_t                        mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]     wr_ptr;
  logic [$clog2(DEPTH)-1:0]     rd_ptr;
  logic [$clog2(DEPTH+1)-1:0]   count;
  logic                         do_deq;

  // pointer step with wrap at DEPTH
  function automatic logic [$clog2(DEPTH)-1:0] next_ptr(
    input logic [$clog2(DEPTH)-1:0] p
  );
    return (p == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign head_valid = (count != '0);
  assign head       = mem[rd_ptr];

  // a dequeue of an empty queue is ignored
  assign do_deq = deq && head_valid;
  // slot freed now, credit back now
  assign credit = do_deq;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (in.valid)
        wr_ptr <= next_ptr(wr_ptr);
      if (do_deq)
        rd_ptr <= next_ptr(rd_ptr);
      // sender never writes without a credit, so no overflow check
      if (in.valid && !do_deq)
        count <= count + 1'b1;
      else if (!in.valid && do_deq)
        count <= count - 1'b1;
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (in.valid)
      mem[wr_ptr] <= in.data;
  end

endmodule

//--- source/inst_decode.sv
//--------------------------------------------------------------------------
// D stage; buffers instructions and manager words, decodes the head,
// reads operands and issues to X when no hazard or hold is present
//--------------------------------------------------------------------------

`timescale 1ns/100ps

module inst_decode (
  input  logic                      clk,
  input  logic                      reset,
  input  core_pipe_pkg::inst_chan_t inst_in,
  output logic                      inst_credit,
  input  core_pipe_pkg::word_chan_t mngr_in,
  output logic                      mngr_credit,
  output core_isa_pkg::reg_addr_t   raddr_a,
  output core_isa_pkg::reg_addr_t   raddr_b,
  input  core_isa_pkg::word_t       rdata_a,
  input  core_isa_pkg::word_t       rdata_b,
  input  core_pipe_pkg::dest_t      x_dest,
  input  core_pipe_pkg::dest_t      w_dest,
  input  logic                      x_hold,
  output logic                      issue,
  output core_pipe_pkg::exec_op_t   op
);

  import core_isa_pkg::*;
  import core_pipe_pkg::*;

  word_chan_t iq_in;
  word_t      iq_head;
  word_t      mq_head;
  logic       iq_valid;
  logic       mq_valid;
  inst_t      inst;
  logic       use_a;
  logic       use_b;
  logic       need_mngr;
  logic       hazard;

  // true if a younger stage will write this source register
  function automatic logic hits(input reg_addr_t rs, input dest_t d);
    return d.wen && (d.rd != '0) && (d.rd == rs);
  endfunction

  //------------------------------------------------------------------------
  // input queues
  //------------------------------------------------------------------------

  // instructions travel through the queue as plain words
  assign iq_in.valid = inst_in.valid;
  assign iq_in.data  = inst_in.inst;

  credit_queue #(.DEPTH(INST_CREDITS)) i_inst_queue (
    .clk        (clk),
    .reset      (reset),
    .in         (iq_in),
    .credit     (inst_credit),
    .deq        (issue),
    .head       (iq_head),
    .head_valid (iq_valid)
  );

  // csrr consumes a manager word only when it issues
  credit_queue #(.DEPTH(MNGR_CREDITS)) i_mngr_queue (
    .clk        (clk),
    .reset      (reset),
    .in         (mngr_in),
    .credit     (mngr_credit),
    .deq        (issue && need_mngr),
    .head       (mq_head),
    .head_valid (mq_valid)
  );

  //------------------------------------------------------------------------
  // decode table
  //------------------------------------------------------------------------

  assign inst    = iq_head;
  // rs1 sits at the same bits in both formats
  assign raddr_a = inst.r.rs1;
  assign raddr_b = inst.r.rs2;

  always_comb begin
    // default is an instruction that writes nothing
    op.alu_fn  = ALU_PASS_A;
    op.op_a    = rdata_a;
    op.op_b    = rdata_b;
    op.rd      = inst.r.rd;
    op.wen     = 1'b0;
    op.to_mngr = 1'b0;
    use_a      = 1'b0;
    use_b      = 1'b0;
    need_mngr  = 1'b0;

    if (inst.r.opcode == OPC_OP) begin
      use_a  = 1'b1;
      use_b  = 1'b1;
      op.wen = 1'b1;
      case (inst.r.funct3)
        3'b000:  op.alu_fn = (inst.r.funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
        3'b001:  op.alu_fn = ALU_SLL;
        3'b010:  op.alu_fn = ALU_SLT;
        3'b011:  op.alu_fn = ALU_SLTU;
        3'b100:  op.alu_fn = ALU_XOR;
        3'b101:  op.alu_fn = (inst.r.funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
        3'b110:  op.alu_fn = ALU_OR;
        default: op.alu_fn = ALU_AND;
      endcase
      // alt funct7 is legal only for sub and sra, anything else is a no-op
      if (!(inst.r.funct7 == F7_BASE ||
            (inst.r.funct7 == F7_ALT &&
             (inst.r.funct3 == 3'b000 || inst.r.funct3 == 3'b101)))) begin
        use_a  = 1'b0;
        use_b  = 1'b0;
        op.wen = 1'b0;
      end
    end else if (inst.c.opcode == OPC_SYSTEM) begin
      if (inst.c.funct3 == F3_CSRR && inst.c.csr == CSR_MNGR2PROC) begin
        // csrr passes the manager word through the ALU
        need_mngr = 1'b1;
        op.op_a   = mq_head;
        op.wen    = 1'b1;
      end else if (inst.c.funct3 == F3_CSRW && inst.c.csr == CSR_PROC2MNGR) begin
        use_a      = 1'b1;
        op.to_mngr = 1'b1;
      end
    end
  end

  //------------------------------------------------------------------------
  // stall and issue
  //------------------------------------------------------------------------

  // no bypassing, wait until X and W no longer hold the write
  assign hazard = (use_a && (hits(inst.r.rs1, x_dest) || hits(inst.r.rs1, w_dest)))
               || (use_b && (hits(inst.r.rs2, x_dest) || hits(inst.r.rs2, w_dest)));

  assign issue = iq_valid && !hazard && !x_hold && (!need_mngr || mq_valid);

endmodule

//--- source/reg_file.sv
//--------------------------------------------------------------------------
// integer register file, two combinational reads and one write,
// x0 reads as zero
//--------------------------------------------------------------------------

`timescale 1ns/100ps

module reg_file (
  input  logic                     clk,
  input  core_isa_pkg::reg_addr_t  raddr_a,
  input  core_isa_pkg::reg_addr_t  raddr_b,
  output core_isa_pkg::word_t      rdata_a,
  output core_isa_pkg::word_t      rdata_b,
  input  logic                     wen,
  input  core_isa_pkg::reg_addr_t  waddr,
  input  core_isa_pkg::word_t      wdata
);

  import core_isa_pkg::*;

  // x1..x31 only
  word_t regs [1:31];

  assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
  assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

  // writes to x0 are dropped
  always_ff @(posedge clk) begin
    if (wen && waddr != '0)
      regs[waddr] <= wdata;
  end

endmodule

//--- source/result_writeback.sv
//--------------------------------------------------------------------------
// W stage; retires one entry per cycle into the register file and the
// manager output, stalls on csrw while no output credit is left
//--------------------------------------------------------------------------

`timescale 1ns/100ps

module result_writeback (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      res_valid,
  input  core_pipe_pkg::result_t    res,
  output logic                      w_hold,
  output core_pipe_pkg::dest_t      w_dest,
  output logic                      rf_wen,
  output core_isa_pkg::reg_addr_t   rf_waddr,
  output core_isa_pkg::word_t       rf_wdata,
  output core_pipe_pkg::word_chan_t mngr_out,
  input  logic                      mngr_out_credit,
  output logic                      commit
);

  import core_pipe_pkg::*;

  logic                               valid_w;
  result_t                            entry_w;
  logic [$clog2(OUT_CREDITS+1)-1:0]   out_credits;
  logic                               retire;

  // csrw needs a credit to leave
  assign w_hold = valid_w && entry_w.to_mngr && (out_credits == '0);
  assign retire = valid_w && !w_hold;

  always_ff @(posedge clk) begin
    if (reset)
      valid_w <= 1'b0;
    else if (!w_hold)
      valid_w <= res_valid;
  end

  always_ff @(posedge clk) begin
    if (!w_hold && res_valid)
      entry_w <= res;
  end

  assign w_dest.wen = valid_w && entry_w.wen;
  assign w_dest.rd  = entry_w.rd;

  // register write at retire
  assign rf_wen   = retire && entry_w.wen;
  assign rf_waddr = entry_w.rd;
  assign rf_wdata = entry_w.value;

  // manager output, one beat per csrw
  assign mngr_out.valid = retire && entry_w.to_mngr;
  assign mngr_out.data  = entry_w.value;

  assign commit = retire;

  //------------------------------------------------------------------------
  // output credit counter
  //------------------------------------------------------------------------

  // send and return in the same cycle cancel out
  always_ff @(posedge clk) begin
    if (reset)
      out_credits <= ($clog2(OUT_CREDITS + 1))'(OUT_CREDITS);
    else if (mngr_out.valid && !mngr_out_credit)
      out_credits <= out_credits - 1'b1;
    else if (!mngr_out.valid && mngr_out_credit)
      out_credits <= out_credits + 1'b1;
  end

endmodule

//--- source/tiny_core.sv
//--------------------------------------------------------------------------
// three-stage core top; D, X and W stages around the register file,
// all external traffic on credit channels
//--------------------------------------------------------------------------

`timescale 1ns/100ps

module tiny_core (
  input  logic                      clk,
  input  logic                      reset,
  input  core_pipe_pkg::inst_chan_t inst_in,
  output logic                      inst_credit,
  input  core_pipe_pkg::word_chan_t mngr_in,
  output logic                      mngr_credit,
  output core_pipe_pkg::word_chan_t mngr_out,
  input  logic                      mngr_out_credit,
  output logic                      commit
);

  import core_isa_pkg::*;
  import core_pipe_pkg::*;

  // D to X
  logic      issue;
  exec_op_t  op;
  logic      x_hold;
  dest_t     x_dest;
  // X to W
  logic      res_valid;
  result_t   res;
  logic      w_hold;
  dest_t     w_dest;
  // register file ports
  reg_addr_t raddr_a;
  reg_addr_t raddr_b;
  word_t     rdata_a;
  word_t     rdata_b;
  logic      rf_wen;
  reg_addr_t rf_waddr;
  word_t     rf_wdata;

  inst_decode i_decode (
    .clk         (clk),
    .reset       (reset),
    .inst_in     (inst_in),
    .inst_credit (inst_credit),
    .mngr_in     (mngr_in),
    .mngr_credit (mngr_credit),
    .raddr_a     (raddr_a),
    .raddr_b     (raddr_b),
    .rdata_a     (rdata_a),
    .rdata_b     (rdata_b),
    .x_dest      (x_dest),
    .w_dest      (w_dest),
    .x_hold      (x_hold),
    .issue       (issue),
    .op          (op)
  );

  alu_execute i_execute (
    .clk       (clk),
    .reset     (reset),
    .issue     (issue),
    .op        (op),
    .w_hold    (w_hold),
    .x_hold    (x_hold),
    .x_dest    (x_dest),
    .res_valid (res_valid),
    .res       (res)
  );

  result_writeback i_writeback (
    .clk             (clk),
    .reset           (reset),
    .res_valid       (res_valid),
    .res             (res),
    .w_hold          (w_hold),
    .w_dest          (w_dest),
    .rf_wen          (rf_wen),
    .rf_waddr        (rf_waddr),
    .rf_wdata        (rf_wdata),
    .mngr_out        (mngr_out),
    .mngr_out_credit (mngr_out_credit),
    .commit          (commit)
  );

  reg_file i_reg_file (
    .clk     (clk),
    .raddr_a (raddr_a),
    .raddr_b (raddr_b),
    .rdata_a (rdata_a),
    .rdata_b (rdata_b),
    .wen     (rf_wen),
    .waddr   (rf_waddr),
    .wdata   (rf_wdata)
  );

endmodule

//--- tiny_core.f
source/core_isa_pkg.sv
source/core_pipe_pkg.sv
source/credit_queue.sv
source/reg_file.sv
source/inst_decode.sv
source/alu_execute.sv
source/result_writeback.sv
source/tiny_core.sv
bench/tiny_core_props.sv
bench/tiny_core_tb.sv
